// File: rtl/mem_share_pkg.sv
package mem_share_pkg;

	// Client side
	localparam int N_PORTS = 4;
	localparam int PORT_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

	// Storage geometry
	localparam int ADDR_W = 8;
	localparam int DATA_W = 16;
	localparam int MEM_WORDS = 2 ** ADDR_W;

	// Cycles from engine acceptance of a read to rd_valid
	localparam int MEM_LAT = 3;

	// Enough bits to count 0 to MEM_LAT reads in flight
	localparam int LVL_W = $clog2(MEM_LAT + 1);

	// One bit per client port, exactly one set for a live request
	typedef logic [N_PORTS-1:0] port_id_t;

	typedef logic [ADDR_W-1:0] addr_t;

	typedef logic [DATA_W-1:0] data_t;

	typedef logic [LVL_W-1:0] lvl_t;

endpackage

// File: rtl/req_buf.sv
`timescale 1ns/1ps

module req_buf #(
	parameter int LANES = 1
) (
	input  logic                    clkSYS,
	input  logic                    arst_n,

	// Upstream side, one request per lane
	input  logic [LANES-1:0]        up_req,
	input  mem_share_pkg::addr_t    up_addr[LANES],
	input  mem_share_pkg::data_t    up_data[LANES],
	input  logic                    up_wr[LANES],
	input  mem_share_pkg::port_id_t up_id[LANES],
	output logic [LANES-1:0]        up_ack,

	// Downstream side, registered copy of each lane
	output logic [LANES-1:0]        dn_req,
	output mem_share_pkg::addr_t    dn_addr[LANES],
	output mem_share_pkg::data_t    dn_data[LANES],
	output logic                    dn_wr[LANES],
	output mem_share_pkg::port_id_t dn_id[LANES],
	input  logic [LANES-1:0]        dn_ack
);

	// Lane holds a valid entry
	logic [LANES-1:0] full;

	// Lane takes a new entry this cycle
	logic [LANES-1:0] load;

	// Room when empty, or when the held entry leaves this cycle
	assign load = up_req & (~full | dn_ack);

	assign up_ack = load;
	assign dn_req = full;

	always_ff @(posedge clkSYS or negedge arst_n)
	begin
		if (!arst_n)
		begin
			full <= '0;
		end
		else
		begin
			// New entry wins over the drain of the old one
			full <= load | (full & ~dn_ack);
		end
	end

	// Entry payload, only written on load
	always_ff @(posedge clkSYS)
	begin
		for (int i = 0; i < LANES; i++)
		begin
			if (load[i])
			begin
				dn_addr[i] <= up_addr[i];
				dn_data[i] <= up_data[i];
				dn_wr[i]   <= up_wr[i];
				dn_id[i]   <= up_id[i];
			end
		end
	end

endmodule

// File: rtl/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter (
	input  logic                                clkSYS,
	input  logic                                arst_n,

	// Buffered port requests
	input  logic [mem_share_pkg::N_PORTS-1:0]   in_req,
	input  mem_share_pkg::addr_t                in_addr[mem_share_pkg::N_PORTS],
	input  mem_share_pkg::data_t                in_data[mem_share_pkg::N_PORTS],
	input  logic                                in_wr[mem_share_pkg::N_PORTS],
	output logic [mem_share_pkg::N_PORTS-1:0]   in_ack,

	// Winner, tagged with its port
	output logic                                out_req,
	output mem_share_pkg::addr_t                out_addr,
	output mem_share_pkg::data_t                out_data,
	output logic                                out_wr,
	output mem_share_pkg::port_id_t             out_id,
	input  logic                                out_ack
);

	import mem_share_pkg::*;

	// First port to look at in the next search
	logic [PORT_W-1:0] prio;

	logic [PORT_W-1:0] win_idx;
	logic              found;
	port_id_t          win_id;

	// Output register free or emptied this cycle
	logic              take;

	logic              out_full;

	// Search from prio upwards with wrap
	always_comb
	begin
		int idx;

		found   = 1'b0;
		win_idx = prio;
		for (int k = 0; k < N_PORTS; k++)
		begin
			idx = (int'(prio) + k) % N_PORTS;
			if (!found && in_req[idx])
			begin
				found   = 1'b1;
				win_idx = PORT_W'(idx);
			end
		end
	end

	assign win_id = found ? (port_id_t'(1) << win_idx) : '0;
	assign take   = ~out_full | out_ack;
	assign in_ack = take ? win_id : '0;
	assign out_req = out_full;

	always_ff @(posedge clkSYS or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out_full <= 1'b0;
			prio     <= '0;
		end
		else if (take)
		begin
			out_full <= found;
			// Next search starts just past the granted port
			if (found)
				prio <= PORT_W'((int'(win_idx) + 1) % N_PORTS);
		end
	end

	always_ff @(posedge clkSYS)
	begin
		if (take && found)
		begin
			out_addr <= in_addr[win_idx];
			out_data <= in_data[win_idx];
			out_wr   <= in_wr[win_idx];
			out_id   <= win_id;
		end
	end

endmodule

// File: rtl/mem_engine.sv
`timescale 1ns/1ps

module mem_engine (
	input  logic                    clkSYS,
	input  logic                    arst_n,

	// Request from the memory lane
	input  logic                    mem_req,
	input  mem_share_pkg::addr_t    mem_addr,
	input  mem_share_pkg::data_t    mem_data,
	input  logic                    mem_wr,
	input  mem_share_pkg::port_id_t mem_id,
	output logic                    mem_ack,

	// Read return
	output mem_share_pkg::data_t    rd_data,
	output mem_share_pkg::port_id_t rd_id,
	output logic                    rd_valid,

	// Reads in flight
	output mem_share_pkg::lvl_t     rd_level,
	output logic                    rd_idle
);

	import mem_share_pkg::*;

	data_t    store [MEM_WORDS];

	// Accepted read this cycle
	logic     rd_take;

	// Read pipeline, stage MEM_LAT-1 is the output
	logic [MEM_LAT-1:0] pipe_vld;
	data_t    pipe_data [MEM_LAT];
	port_id_t pipe_id [MEM_LAT];

	// Never stalls
	assign mem_ack = mem_req;
	assign rd_take = mem_req & ~mem_wr;

	// Writes land at acceptance, so a read one cycle later sees them
	always_ff @(posedge clkSYS)
	begin
		if (mem_req && mem_wr)
			store[mem_addr] <= mem_data;
	end

	always_ff @(posedge clkSYS or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pipe_vld <= '0;
		end
		else
		begin
			pipe_vld[0] <= rd_take;
			for (int k = 1; k < MEM_LAT; k++)
				pipe_vld[k] <= pipe_vld[k-1];
		end
	end

	// Data and port travel alongside the valid bits
	always_ff @(posedge clkSYS)
	begin
		if (rd_take)
		begin
			pipe_data[0] <= store[mem_addr];
			pipe_id[0]   <= mem_id;
		end
		for (int k = 1; k < MEM_LAT; k++)
		begin
			pipe_data[k] <= pipe_data[k-1];
			pipe_id[k]   <= pipe_id[k-1];
		end
	end

	assign rd_valid = pipe_vld[MEM_LAT-1];
	assign rd_data  = pipe_data[MEM_LAT-1];
	assign rd_id    = pipe_id[MEM_LAT-1];

	// Up on acceptance, down on return, same cycle cancels
	always_ff @(posedge clkSYS or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_level <= '0;
		end
		else
		begin
			case ({rd_take, rd_valid})
				2'b10:   rd_level <= rd_level + 1'b1;
				2'b01:   rd_level <= rd_level - 1'b1;
				default: rd_level <= rd_level;
			endcase
		end
	end

	assign rd_idle = (rd_level == '0);

endmodule

// File: rtl/mem_share_top.sv
`timescale 1ns/1ps

module mem_share_top (
	input  logic                              clkSYS,
	input  logic                              arst_n,

	// Client requests
	input  logic [mem_share_pkg::N_PORTS-1:0] arb_req,
	input  mem_share_pkg::addr_t              arb_addr[mem_share_pkg::N_PORTS],
	input  mem_share_pkg::data_t              arb_data[mem_share_pkg::N_PORTS],
	input  logic                              arb_wr[mem_share_pkg::N_PORTS],
	output logic [mem_share_pkg::N_PORTS-1:0] arb_ack,

	// Read return, one-hot valid per port
	output mem_share_pkg::data_t              arb_data_out,
	output mem_share_pkg::port_id_t           arb_valid,

	// Engine status
	output mem_share_pkg::lvl_t               rd_level,
	output logic                              rd_idle
);

	import mem_share_pkg::*;

	// Port buffer to arbiter
	logic [N_PORTS-1:0] in_req;
	logic [N_PORTS-1:0] in_ack;
	addr_t    in_addr[N_PORTS];
	data_t    in_data[N_PORTS];
	logic     in_wr[N_PORTS];

	// Arbiter to memory lane, single lane kept as arrays of one
	logic [0:0] out_req;
	logic [0:0] out_ack;
	addr_t    out_addr[1];
	data_t    out_data[1];
	logic     out_wr[1];
	port_id_t out_id[1];

	// Memory lane to engine
	logic [0:0] mem_req;
	logic [0:0] mem_ack;
	addr_t    mem_addr[1];
	data_t    mem_data[1];
	logic     mem_wr[1];
	port_id_t mem_id[1];

	// Engine return
	data_t    rd_data;
	port_id_t rd_id;
	logic     rd_valid;

	// Port identity is attached later by the arbiter
	req_buf #(.LANES(N_PORTS)) i_port_buf (
		.clkSYS  (clkSYS),
		.arst_n  (arst_n),
		.up_req  (arb_req),
		.up_addr (arb_addr),
		.up_data (arb_data),
		.up_wr   (arb_wr),
		.up_id   (),
		.up_ack  (arb_ack),
		.dn_req  (in_req),
		.dn_addr (in_addr),
		.dn_data (in_data),
		.dn_wr   (in_wr),
		.dn_id   (),
		.dn_ack  (in_ack)
	);

	rr_arbiter i_arb (
		.clkSYS   (clkSYS),
		.arst_n   (arst_n),
		.in_req   (in_req),
		.in_addr  (in_addr),
		.in_data  (in_data),
		.in_wr    (in_wr),
		.in_ack   (in_ack),
		.out_req  (out_req[0]),
		.out_addr (out_addr[0]),
		.out_data (out_data[0]),
		.out_wr   (out_wr[0]),
		.out_id   (out_id[0]),
		.out_ack  (out_ack[0])
	);

	req_buf #(.LANES(1)) i_mem_buf (
		.clkSYS  (clkSYS),
		.arst_n  (arst_n),
		.up_req  (out_req),
		.up_addr (out_addr),
		.up_data (out_data),
		.up_wr   (out_wr),
		.up_id   (out_id),
		.up_ack  (out_ack),
		.dn_req  (mem_req),
		.dn_addr (mem_addr),
		.dn_data (mem_data),
		.dn_wr   (mem_wr),
		.dn_id   (mem_id),
		.dn_ack  (mem_ack)
	);

	mem_engine i_engine (
		.clkSYS   (clkSYS),
		.arst_n   (arst_n),
		.mem_req  (mem_req[0]),
		.mem_addr (mem_addr[0]),
		.mem_data (mem_data[0]),
		.mem_wr   (mem_wr[0]),
		.mem_id   (mem_id[0]),
		.mem_ack  (mem_ack[0]),
		.rd_data  (rd_data),
		.rd_id    (rd_id),
		.rd_valid (rd_valid),
		.rd_level (rd_level),
		.rd_idle  (rd_idle)
	);

	// Return register, valid routed to the owning port
	always_ff @(posedge clkSYS or negedge arst_n)
	begin
		if (!arst_n)
			arb_valid <= '0;
		else
			arb_valid <= rd_id & {N_PORTS{rd_valid}};
	end

	always_ff @(posedge clkSYS)
	begin
		arb_data_out <= rd_data;
	end

endmodule

// File: verif/mem_share_checker.sv
`timescale 1ns/1ps

module mem_share_checker (
	input logic                              clkSYS,
	input logic                              arst_n,
	input logic [mem_share_pkg::N_PORTS-1:0] arb_req,
	input mem_share_pkg::addr_t              arb_addr[mem_share_pkg::N_PORTS],
	input mem_share_pkg::data_t              arb_data[mem_share_pkg::N_PORTS],
	input logic                              arb_wr[mem_share_pkg::N_PORTS],
	input logic [mem_share_pkg::N_PORTS-1:0] arb_ack,
	input mem_share_pkg::port_id_t           arb_valid,
	input mem_share_pkg::lvl_t               rd_level,
	input logic                              rd_idle
);

	import mem_share_pkg::*;

	// Client requests hold until acknowledged
	for (genvar p = 0; p < N_PORTS; p++)
	begin : g_port
		a_req_hold: assert property (@(posedge clkSYS) disable iff (!arst_n)
			arb_req[p] && !arb_ack[p] |=> arb_req[p] && $stable(arb_addr[p])
				&& $stable(arb_data[p]) && $stable(arb_wr[p]))
			else $error("port %0d request changed before ack", p);
	end

	a_valid_onehot: assert property (@(posedge clkSYS) disable iff (!arst_n)
		$onehot0(arb_valid))
		else $error("arb_valid names more than one port");

	a_idle_level: assert property (@(posedge clkSYS) disable iff (!arst_n)
		rd_idle == (rd_level == '0))
		else $error("rd_idle disagrees with rd_level");

endmodule

bind mem_share_top mem_share_checker i_checker (
	.clkSYS    (clkSYS),
	.arst_n    (arst_n),
	.arb_req   (arb_req),
	.arb_addr  (arb_addr),
	.arb_data  (arb_data),
	.arb_wr    (arb_wr),
	.arb_ack   (arb_ack),
	.arb_valid (arb_valid),
	.rd_level  (rd_level),
	.rd_idle   (rd_idle)
);

// File: verif/tb_mem_share.sv
`timescale 1ns/1ps

module tb_mem_share;

	import mem_share_pkg::*;

	localparam int MAX_LINES = 64;
	localparam int RESET_CYCLES = 10;
	// Worst case from port acceptance of a write until it lands in storage
	localparam int SETTLE = N_PORTS + 4;

	logic               clkSYS;
	logic               arst_n;
	logic [N_PORTS-1:0] arb_req;
	addr_t              arb_addr[N_PORTS];
	data_t              arb_data[N_PORTS];
	logic               arb_wr[N_PORTS];
	logic [N_PORTS-1:0] arb_ack;
	data_t              arb_data_out;
	port_id_t           arb_valid;
	lvl_t               rd_level;
	logic               rd_idle;

	// Pattern word: group, port, op, address, write data, expected read data
	logic [55:0] pat_mem [MAX_LINES];
	int          n_lines;
	logic        patterns_loaded;

	data_t    ref_mem [MEM_WORDS];
	data_t    exp_q [N_PORTS][$];
	port_id_t order_q [$];
	int       port_lines [N_PORTS][$];
	int       last_port;
	int       ports_done;
	logic     group_lockstep;
	int       seed;

	mem_share_top i_dut (
		.clkSYS       (clkSYS),
		.arst_n       (arst_n),
		.arb_req      (arb_req),
		.arb_addr     (arb_addr),
		.arb_data     (arb_data),
		.arb_wr       (arb_wr),
		.arb_ack      (arb_ack),
		.arb_data_out (arb_data_out),
		.arb_valid    (arb_valid),
		.rd_level     (rd_level),
		.rd_idle      (rd_idle)
	);

	initial
	begin
		clkSYS = 1'b0;
		forever
			#2 clkSYS = ~clkSYS;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_data(input string name, input data_t act, input data_t exp);
		if (act !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, act, exp));
	endtask

	task automatic check_id(input string name, input port_id_t act, input port_id_t exp);
		if (act !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, act, exp));
	endtask

	task automatic check_level(input string name, input lvl_t act, input lvl_t exp);
		if (act !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, act, exp));
	endtask

	function automatic int pending_reads();
		int n;
		n = 0;
		for (int p = 0; p < N_PORTS; p++)
			n += exp_q[p].size();
		return n;
	endfunction

	// Entered 1 ns after a rising edge, left the same way
	task automatic send_request(input int p, input logic [55:0] w);
		addr_t a;
		data_t d;
		a = w[39:32];
		d = w[31:16];
		arb_req[p] = 1'b1;
		arb_addr[p] = a;
		arb_data[p] = d;
		arb_wr[p] = w[40];
		@(negedge clkSYS);
		while (arb_ack[p] !== 1'b1)
			@(negedge clkSYS);
		// Transfer at the coming edge, so the model moves now
		if (w[40])
			ref_mem[a] = d;
		else
		begin
			check_data("pattern expected data", w[15:0], ref_mem[a]);
			exp_q[p].push_back(ref_mem[a]);
		end
		@(posedge clkSYS);
		#1;
		arb_req[p] = 1'b0;
	endtask

	task automatic drive_port(input int p);
		int idx;
		int gap;
		while (port_lines[p].size() != 0)
		begin
			idx = port_lines[p].pop_front();
			if (!group_lockstep)
			begin
				gap = $unsigned($random(seed)) % 4;
				repeat (gap)
				begin
					@(posedge clkSYS);
					#1;
				end
			end
			send_request(p, pat_mem[idx]);
		end
		ports_done++;
	endtask

	task automatic run_group();
		ports_done = 0;
		for (int p = 0; p < N_PORTS; p++)
		begin
			fork
				automatic int pp = p;
				drive_port(pp);
			join_none
		end
		wait (ports_done == N_PORTS);
		repeat (SETTLE) @(posedge clkSYS);
		while (pending_reads() != 0)
			@(negedge clkSYS);
		@(negedge clkSYS);
		check_level("rd_level", rd_level, '0);
		if (rd_idle !== 1'b1)
			fail_run($sformatf("mismatch at %0t: rd_idle got %b expected 1", $time, rd_idle));
		if (order_q.size() != 0)
			fail_run("lockstep group ended with returns still missing");
		@(posedge clkSYS);
		#1;
	endtask

	// Return monitor, registered outputs sampled mid-cycle
	initial
	begin
		int p;
		int hits;
		int lvl_max;
		forever
		begin
			@(negedge clkSYS);
			// No more reads in flight than the pipeline depth or the reads still owed
			lvl_max = (pending_reads() < MEM_LAT) ? pending_reads() : MEM_LAT;
			if (arst_n && int'(rd_level) > lvl_max)
				fail_run($sformatf("rd_level %0d above its limit %0d at %0t",
					rd_level, lvl_max, $time));
			if (arst_n && arb_valid != '0)
			begin
				hits = 0;
				p = 0;
				for (int i = 0; i < N_PORTS; i++)
				begin
					if (arb_valid[i])
					begin
						hits++;
						p = i;
					end
				end
				if (hits != 1)
					fail_run($sformatf("arb_valid %b names more than one port", arb_valid));
				if (exp_q[p].size() == 0)
					fail_run($sformatf("read return on port %0d with no read outstanding", p));
				check_data("arb_data_out", arb_data_out, exp_q[p].pop_front());
				if (order_q.size() != 0)
					check_id("arb_valid", arb_valid, order_q.pop_front());
				last_port = p;
			end
		end
	end

	initial
	begin
		int budget;
		wait (patterns_loaded === 1'b1);
		budget = n_lines * 4 * (MEM_LAT + 8) + RESET_CYCLES;
		repeat (budget) @(posedge clkSYS);
		fail_run($sformatf("watchdog expired after %0d cycles, the run hung", budget));
	end

	initial
	begin
		int line;
		int p;
		logic [7:0] grp;
		seed = 32'h9528_ab9a;
		arst_n = 1'b0;
		arb_req = '0;
		for (int i = 0; i < N_PORTS; i++)
		begin
			arb_addr[i] = '0;
			arb_data[i] = '0;
			arb_wr[i] = 1'b0;
		end
		last_port = N_PORTS - 1;
		patterns_loaded = 1'b0;
		$readmemh("verif/mem_share_patterns.txt", pat_mem);
		n_lines = 0;
		while (n_lines < MAX_LINES && pat_mem[n_lines][55:48] !== 8'hff)
			n_lines++;
		if (n_lines == 0 || n_lines == MAX_LINES)
			fail_run("pattern file is empty or lacks its end line");
		patterns_loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clkSYS);
		#1;
		arst_n = 1'b1;
		@(posedge clkSYS);
		#1;

		line = 0;
		while (line < n_lines)
		begin
			grp = pat_mem[line][55:48];
			group_lockstep = 1'b0;
			while (line < n_lines && pat_mem[line][55:48] == grp)
			begin
				p = int'(pat_mem[line][47:44]);
				if (p >= N_PORTS)
					fail_run($sformatf("pattern line %0d names port %0d", line, p));
				port_lines[p].push_back(line);
				if (pat_mem[line][41])
					group_lockstep = 1'b1;
				line++;
			end
			// Round robin resumes just past the last granted port
			if (group_lockstep)
				for (int k = 0; k < N_PORTS; k++)
					order_q.push_back(port_id_t'(1) << ((last_port + 1 + k) % N_PORTS));
			run_group();
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

// File: verif/mem_share_patterns.txt
// group_port_op_addr_wdata_expected, all hex, group ff ends the list
// op bit 0 is write, bit 1 launches all ports together with no gap
01_0_1_10_1234_0000
01_0_0_10_0000_1234
01_1_1_20_a5a5_0000
01_1_0_20_0000_a5a5
02_0_1_30_0101_0000
02_1_1_31_0202_0000
02_2_1_32_0303_0000
02_3_1_33_0404_0000
02_0_1_40_1111_0000
02_1_1_41_2222_0000
02_2_1_42_3333_0000
02_3_1_43_4444_0000
03_0_0_33_0000_0404
03_1_0_40_0000_1111
03_2_0_31_0000_0202
03_3_0_42_0000_3333
03_0_0_30_0000_0101
03_1_0_43_0000_4444
03_2_0_41_0000_2222
03_3_0_32_0000_0303
04_2_0_10_0000_1234
05_0_2_30_0000_0101
05_1_2_31_0000_0202
05_2_2_32_0000_0303
05_3_2_33_0000_0404
06_0_0_20_0000_a5a5
07_0_2_40_0000_1111
07_1_2_41_0000_2222
07_2_2_42_0000_3333
07_3_2_43_0000_4444
08_0_1_80_c001_0000
08_0_1_81_c002_0000
08_0_0_80_0000_c001
08_0_0_81_0000_c002
08_0_0_10_0000_1234
08_1_1_90_d001_0000
08_1_0_90_0000_d001
08_1_0_20_0000_a5a5
08_1_0_33_0000_0404
08_2_1_a0_e001_0000
08_2_1_a1_e002_0000
08_2_0_a1_0000_e002
08_2_0_a0_0000_e001
08_3_0_41_0000_2222
08_3_1_b0_f001_0000
08_3_0_b0_0000_f001
08_3_0_42_0000_3333
ff_0_0_00_0000_0000

// File: tb.f
rtl/mem_share_pkg.sv
rtl/req_buf.sv
rtl/rr_arbiter.sv
rtl/mem_engine.sv
rtl/mem_share_top.sv
verif/mem_share_checker.sv
verif/tb_mem_share.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_share \
	-f tb.f -o sim_mem_share
./obj_dir/sim_mem_share
